// File: hw/nocPkg.sv
package nocPkg;

  localparam int numPorts = 5;
  localparam int lenWidth = 12;
  localparam int dataWidth = 16;

  // one-hot flit kind, head is the lowest bit.
  typedef enum logic [2:0]
  {
    kindHead = 3'b001,
    kindBody = 3'b010,
    kindTail = 3'b100
  } flitKindT;

  // input port index, also the cyclic arbitration order.
  typedef enum logic [2:0]
  {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portT;

  // length is only meaningful in a head flit.
  typedef struct packed
  {
    flitKindT kind;
    logic [lenWidth-1:0] length;
    logic [dataWidth-1:0] data;
  } flitT;

endpackage

// File: hw/flitLink.sv
`timescale 1ns/1ps

// flit moves on a rising edge with valid and ready both high.
interface flitLink import nocPkg::*;
();

  logic valid;
  logic ready;
  flitT flit;

  modport source
  (
    output valid,
    output flit,
    input  ready
  );

  modport sink
  (
    input  valid,
    input  flit,
    output ready
  );

endinterface

// File: hw/inputBuffer.sv
`timescale 1ns/1ps

module inputBuffer import nocPkg::*;
#(
  parameter int bufDepth = 4
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  output logic    inReady,
  input  flitT    inFlit,
  flitLink.source out
);

  localparam int ptrW = (bufDepth > 1) ? $clog2(bufDepth) : 1;
  localparam int cntW = $clog2(bufDepth + 1);

  flitT mem [bufDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic [cntW-1:0] nextCount;
  logic wrEn;
  logic rdEn;

  assign wrEn = inValid && inReady;
  assign rdEn = out.valid && out.ready;
  assign nextCount = count + cntW'(wrEn) - cntW'(rdEn);

  // front entry is always on the link.
  assign out.valid = (count != '0);
  assign out.flit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inReady <= 1'b0;
    end
    else
    begin
      if (wrEn)
      begin
        if (wrPtr == ptrW'(bufDepth - 1))
          wrPtr <= '0;
        else
          wrPtr <= wrPtr + 1'b1;
      end
      if (rdEn)
      begin
        if (rdPtr == ptrW'(bufDepth - 1))
          rdPtr <= '0;
        else
          rdPtr <= rdPtr + 1'b1;
      end
      count <= nextCount;
      // registered so ready stays low for a cycle after reset.
      inReady <= (nextCount != cntW'(bufDepth));
    end
  end

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= inFlit;
  end

  noOverflow: assert property (@(posedge clk) disable iff (rst)
    !(wrEn && (count == cntW'(bufDepth))) && !(rdEn && (count == '0)));

endmodule

// File: hw/holdTimer.sv
`timescale 1ns/1ps

module holdTimer import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                xfer,
  input  flitKindT            xferKind,
  input  logic [lenWidth-1:0] xferLength,
  input  logic                runTimer,
  output logic                timesUp
);

  logic [lenWidth-1:0] limit;
  logic [lenWidth-1:0] count;
  logic headXfer;

  assign headXfer = xfer && (xferKind == kindHead);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headXfer)
        limit <= xferLength;
      // counts flits, not cycles.
      if (!runTimer)
        count <= '0;
      else if (headXfer)
        count <= lenWidth'(1);
      else if (xfer)
        count <= count + 1'b1;
    end
  end

  // a new head can drop the limit below the running count.
  assign timesUp = (count >= limit);

endmodule

// File: hw/portArbiter.sv
`timescale 1ns/1ps

module portArbiter import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] req,
  input  logic [numPorts-1:0] timesUp,
  output logic [numPorts-1:0] grant,
  output logic [numPorts-1:0] runTimer
);

  // bit 0 is idle, bit p+1 is port p.
  localparam logic [numPorts:0] stIdle = {{numPorts{1'b0}}, 1'b1};

  logic [numPorts:0] state;
  logic [numPorts:0] nextState;

  // first requester after port last, wrapping back to last itself.
  function automatic logic [numPorts:0] searchFrom(input int last,
                                                   input logic [numPorts-1:0] r);
    logic [numPorts:0] pick;
    logic found;
    int idx;
    pick = stIdle;
    found = 1'b0;
    for (int i = 1; i <= numPorts; i++)
    begin
      idx = (last + i) % numPorts;
      if (!found && r[idx])
      begin
        pick = '0;
        pick[idx + 1] = 1'b1;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = stIdle;
    runTimer = '0;
    // from idle the search starts at Local.
    if (state[0])
      nextState = searchFrom(numPorts - 1, req);
    for (int p = 0; p < numPorts; p++)
    begin
      if (state[p + 1])
      begin
        if (req[p] && !timesUp[p])
        begin
          nextState = state;
          runTimer[p] = 1'b1;
        end
        else
        begin
          nextState = searchFrom(p, req);
        end
      end
    end
  end

  assign grant = state[numPorts:1];

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

  // a fresh grant must follow a request.
  grantHasReq: assert property (@(posedge clk) disable iff (rst)
    (grant & ~$past(grant) & ~$past(req)) == '0);

endmodule

// File: hw/outputStage.sv
`timescale 1ns/1ps

module outputStage import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  flitLink.sink               in [numPorts],
  input  logic [numPorts-1:0] grant,
  output logic                outValid,
  input  logic                outReady,
  output flitT                outFlit,
  output portT                outSrc
);

  logic [numPorts-1:0] linkValid;
  flitT linkFlit [numPorts];
  logic canLoad;
  logic selValid;
  flitT selFlit;
  portT selSrc;

  // register is free, or it drains this cycle.
  assign canLoad = !outValid || outReady;

  for (genvar i = 0; i < numPorts; i++)
  begin : gLink
    assign linkValid[i] = in[i].valid;
    assign linkFlit[i] = in[i].flit;
    assign in[i].ready = grant[i] && canLoad;
  end

  always_comb
  begin
    selFlit = '0;
    selSrc = portLocal;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        selFlit = linkFlit[i];
        selSrc = portT'(i);
      end
    end
  end

  assign selValid = |(grant & linkValid);

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (canLoad)
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    if (canLoad && selValid)
    begin
      outFlit <= selFlit;
      outSrc <= selSrc;
    end
  end

  holdOnStall: assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outFlit) && $stable(outSrc));

endmodule

// File: hw/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort import nocPkg::*;
#(
  parameter int bufDepth = 4
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lValid,
  output logic                 lReady,
  input  flitKindT             lKind,
  input  logic [lenWidth-1:0]  lLength,
  input  logic [dataWidth-1:0] lData,
  input  logic                 nValid,
  output logic                 nReady,
  input  flitKindT             nKind,
  input  logic [lenWidth-1:0]  nLength,
  input  logic [dataWidth-1:0] nData,
  input  logic                 eValid,
  output logic                 eReady,
  input  flitKindT             eKind,
  input  logic [lenWidth-1:0]  eLength,
  input  logic [dataWidth-1:0] eData,
  input  logic                 wValid,
  output logic                 wReady,
  input  flitKindT             wKind,
  input  logic [lenWidth-1:0]  wLength,
  input  logic [dataWidth-1:0] wData,
  input  logic                 sValid,
  output logic                 sReady,
  input  flitKindT             sKind,
  input  logic [lenWidth-1:0]  sLength,
  input  logic [dataWidth-1:0] sData,
  output logic                 outValid,
  input  logic                 outReady,
  output flitKindT             outKind,
  output logic [lenWidth-1:0]  outLength,
  output logic [dataWidth-1:0] outData,
  output portT                 outSrc
);

  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  logic [numPorts-1:0] req;
  logic [numPorts-1:0] xfer;
  logic [numPorts-1:0] grant;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;
  flitT inFlit [numPorts];
  flitT outFlit;

  flitLink links [numPorts] ();

  assign inValid = {sValid, wValid, eValid, nValid, lValid};
  assign {sReady, wReady, eReady, nReady, lReady} = inReady;

  assign inFlit[portLocal] = '{kind: lKind, length: lLength, data: lData};
  assign inFlit[portNorth] = '{kind: nKind, length: nLength, data: nData};
  assign inFlit[portEast]  = '{kind: eKind, length: eLength, data: eData};
  assign inFlit[portWest]  = '{kind: wKind, length: wLength, data: wData};
  assign inFlit[portSouth] = '{kind: sKind, length: sLength, data: sData};

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    inputBuffer #(.bufDepth(bufDepth)) inBuf
    (
      .clk(clk),
      .rst(rst),
      .inValid(inValid[i]),
      .inReady(inReady[i]),
      .inFlit(inFlit[i]),
      .out(links[i])
    );

    assign req[i] = links[i].valid;
    assign xfer[i] = links[i].valid && links[i].ready;

    holdTimer holdTmr
    (
      .clk(clk),
      .rst(rst),
      .xfer(xfer[i]),
      .xferKind(links[i].flit.kind),
      .xferLength(links[i].flit.length),
      .runTimer(runTimer[i]),
      .timesUp(timesUp[i])
    );
  end

  portArbiter arbiter0
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .timesUp(timesUp),
    .grant(grant),
    .runTimer(runTimer)
  );

  outputStage outStage0
  (
    .clk(clk),
    .rst(rst),
    .in(links),
    .grant(grant),
    .outValid(outValid),
    .outReady(outReady),
    .outFlit(outFlit),
    .outSrc(outSrc)
  );

  assign outKind = outFlit.kind;
  assign outLength = outFlit.length;
  assign outData = outFlit.data;

endmodule

// File: sim/tbRouter.sv
`timescale 1ns/1ps

module tbRouter import nocPkg::*;
();

  localparam int maxCases = 64;
  localparam int timeoutCycles = 2000;

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  flitT inFlit [numPorts];
  logic outValid;
  logic outReady;
  flitKindT outKind;
  logic [lenWidth-1:0] outLength;
  logic [dataWidth-1:0] outData;
  portT outSrc;

  logic [43:0] caseMem [maxCases];
  logic stallPat [maxCases];
  int nCases;
  flitT pend [numPorts][$];
  flitT expQ [numPorts][$];
  int lastLen [numPorts];

  // output monitor state.
  logic stallSeen;
  flitT heldFlit;
  portT heldSrc;
  int runSrc;
  int runCount;
  int lastSrc;
  bit haveLast;
  bit soloPhase;
  int delivered;

  routerOutputPort #(.bufDepth(4)) dut0
  (
    .clk(clk),
    .rst(rst),
    .lValid(inValid[0]),
    .lReady(inReady[0]),
    .lKind(inFlit[0].kind),
    .lLength(inFlit[0].length),
    .lData(inFlit[0].data),
    .nValid(inValid[1]),
    .nReady(inReady[1]),
    .nKind(inFlit[1].kind),
    .nLength(inFlit[1].length),
    .nData(inFlit[1].data),
    .eValid(inValid[2]),
    .eReady(inReady[2]),
    .eKind(inFlit[2].kind),
    .eLength(inFlit[2].length),
    .eData(inFlit[2].data),
    .wValid(inValid[3]),
    .wReady(inReady[3]),
    .wKind(inFlit[3].kind),
    .wLength(inFlit[3].length),
    .wData(inFlit[3].data),
    .sValid(inValid[4]),
    .sReady(inReady[4]),
    .sKind(inFlit[4].kind),
    .sLength(inFlit[4].length),
    .sData(inFlit[4].data),
    .outValid(outValid),
    .outReady(outReady),
    .outKind(outKind),
    .outLength(outLength),
    .outData(outData),
    .outSrc(outSrc)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic failWith(input string msg);
    $display("failure: %s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic checkIdle();
    compare("outValid", 32'(outValid), 32'h0);
    compare("inReady", 32'(inReady), 32'h0);
  endtask

  function automatic bit allEmpty();
    bit empty;
    empty = 1'b1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (pend[p].size() != 0 || expQ[p].size() != 0)
        empty = 1'b0;
    end
    return empty;
  endfunction

  // word is phase, port, kind, length, data, stall.
  task automatic loadPhase(input int ph);
    flitT f;
    int p;
    for (int i = 0; i < nCases; i++)
    begin
      if (int'(caseMem[i][43:40]) == ph)
      begin
        p = int'(caseMem[i][39:36]);
        f.kind = flitKindT'(caseMem[i][34:32]);
        f.length = caseMem[i][31:20];
        f.data = caseMem[i][19:4];
        pend[p].push_back(f);
        expQ[p].push_back(f);
      end
    end
  endtask

  task automatic checkOutput();
    flitT expFlit;
    int src;
    bit loaded;
    bit others;
    if (soloPhase && delivered != 0)
      compare("outValid", 32'(outValid), 32'h1);
    if (stallSeen)
    begin
      compare("outValid", 32'(outValid), 32'h1);
      compare("outKind", 32'(outKind), 32'(heldFlit.kind));
      compare("outLength", 32'(outLength), 32'(heldFlit.length));
      compare("outData", 32'(outData), 32'(heldFlit.data));
      compare("outSrc", 32'(outSrc), 32'(heldSrc));
    end
    stallSeen = outValid && !outReady;
    heldFlit = '{kind: outKind, length: outLength, data: outData};
    heldSrc = outSrc;
    if (outValid && outReady)
    begin
      src = int'(outSrc);
      if (src >= numPorts)
        failWith("output names a port that does not exist");
      if (expQ[src].size() == 0)
        failWith("flit arrived from a port with nothing left to send");
      // rotation only holds while every port still has traffic queued.
      loaded = 1'b1;
      for (int p = 0; p < numPorts; p++)
      begin
        if (expQ[p].size() < 2)
          loaded = 1'b0;
      end
      if (loaded && haveLast && src != lastSrc)
        compare("outSrc", 32'(src), 32'((lastSrc + 1) % numPorts));
      expFlit = expQ[src].pop_front();
      compare("outKind", 32'(outKind), 32'(expFlit.kind));
      compare("outLength", 32'(outLength), 32'(expFlit.length));
      compare("outData", 32'(outData), 32'(expFlit.data));
      delivered++;
      if (src != runSrc)
      begin
        runSrc = src;
        runCount = 0;
      end
      if (expFlit.kind == kindHead)
      begin
        lastLen[src] = int'(expFlit.length);
        runCount = 1;
      end
      else
        runCount++;
      others = 1'b0;
      for (int p = 0; p < numPorts; p++)
      begin
        if (p != src && expQ[p].size() != 0)
          others = 1'b1;
      end
      if (others && runCount > lastLen[src] + 1)
        failWith("a port kept the output past its tenure limit");
      lastSrc = src;
      haveLast = 1'b1;
    end
  endtask

  task automatic runPhase(input int ph);
    int cyc;
    int active;
    loadPhase(ph);
    active = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (expQ[p].size() != 0)
        active++;
    end
    // a lone requester keeps the output through timer expiry.
    soloPhase = (active == 1);
    delivered = 0;
    haveLast = 1'b0;
    runSrc = -1;
    runCount = 0;
    stallSeen = 1'b0;
    cyc = 0;
    while (!allEmpty())
    begin
      if (cyc >= timeoutCycles)
        failWith($sformatf("phase %0d did not drain in time", ph));
      @(posedge clk);
      #1;
      outReady = !stallPat[cyc % nCases];
      for (int p = 0; p < numPorts; p++)
      begin
        if (pend[p].size() != 0)
        begin
          inValid[p] = 1'b1;
          inFlit[p] = pend[p][0];
        end
        else
          inValid[p] = 1'b0;
      end
      @(negedge clk);
      for (int p = 0; p < numPorts; p++)
      begin
        if (inValid[p] && inReady[p])
          void'(pend[p].pop_front());
      end
      checkOutput();
      cyc++;
    end
    @(posedge clk);
    #1;
    outReady = 1'b1;
    inValid = '0;
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b1;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] = '0;
      lastLen[p] = 0;
    end
    $readmemh("sim/routerCases.mem", caseMem);
    nCases = 0;
    while (nCases < maxCases && caseMem[nCases][43:40] != 4'hf)
      nCases++;
    if (nCases == 0 || nCases == maxCases)
      failWith("case file is empty or has no end marker");
    for (int i = 0; i < nCases; i++)
      stallPat[i] = caseMem[i][0];

    @(posedge clk);
    repeat (4)
    begin
      @(negedge clk);
      checkIdle();
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
    @(negedge clk);
    checkIdle();

    // all five ports loaded, then a single requester.
    runPhase(1);
    runPhase(2);

    $display("Verification passed");
    $finish;
  end

endmodule

// File: sim/routerCases.mem
// phase_port_kind_length_data_stall, kind 1 head 2 body 4 tail
// phase 1 loads all five ports, phase 2 loads North only, phase f ends the list
1_0_1_001_0100_0
1_0_2_000_0101_0
1_0_4_000_0102_0
1_0_1_002_0103_0
1_0_2_000_0104_0
1_0_4_000_0105_0
1_1_1_002_0200_0
1_1_2_000_0201_0
1_1_4_000_0202_0
1_1_1_001_0203_0
1_1_2_000_0204_0
1_1_4_000_0205_0
1_2_1_003_0300_1
1_2_2_000_0301_1
1_2_4_000_0302_0
1_2_1_001_0303_0
1_2_2_000_0304_0
1_2_4_000_0305_0
1_3_1_001_0400_0
1_3_2_000_0401_0
1_3_4_000_0402_1
1_3_1_003_0403_0
1_3_2_000_0404_0
1_3_4_000_0405_0
1_4_1_002_0500_0
1_4_2_000_0501_0
1_4_4_000_0502_0
1_4_1_002_0503_1
1_4_2_000_0504_0
1_4_4_000_0505_0
2_1_1_001_0900_0
2_1_2_000_0901_0
2_1_2_000_0902_0
2_1_2_000_0903_1
2_1_2_000_0904_0
2_1_4_000_0905_0
f_0_0_000_0000_0

// File: sim.f
hw/nocPkg.sv
hw/flitLink.sv
hw/inputBuffer.sv
hw/holdTimer.sv
hw/portArbiter.sv
hw/outputStage.sv
hw/routerOutputPort.sv
sim/tbRouter.sv

// File: Makefile
# Verilator flow for the router output port testbench.

TOP := tbRouter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
